// File: common/exec_pkg.sv
package exec_pkg;

    typedef logic [31:0] word_t;

    // alu function select
    typedef enum logic [3:0] {
        ADD,
        ADDU,
        SUB,
        SUBU,
        AND,
        OR,
        XOR,
        NOR,
        SLT,
        SLTU,
        SLL,
        SRL,
        SRA,
        LUI
    } alu_op_e;

    typedef enum logic {
        REGB,
        IMM
    } alusrc_e;

    typedef enum logic [2:0] {
        BEQ,
        BNE,
        BLEZ,
        BGTZ,
        BLTZ,
        BGEZ
    } branch_e;

    typedef enum logic [2:0] {
        MD_NONE,
        MULT,
        MULTU,
        DIV,
        DIVU
    } md_op_e;

    // decoded control, 17 bits
    typedef struct packed {
        alu_op_e    alufunc;
        alusrc_e    alusrc;
        logic       zeroext;
        logic       shamt_valid;
        logic       branch;
        branch_e    branch_type;
        logic       jump;
        logic       jr;
        logic       is_link;
        md_op_e     md_op;
    } ctl_t;

    // one issue slot
    typedef struct packed {
        logic        valid;
        word_t       pc;
        word_t       raw_instr;
        word_t       rd1;
        word_t       rd2;
        logic [15:0] imm;
        logic [4:0]  rdst;
        ctl_t        ctl;
    } issue_t;

    // one execute slot
    typedef struct packed {
        logic        valid;
        word_t       pc;
        logic [4:0]  rdst;
        ctl_t        ctl;
        word_t       alu_out;
        word_t       srca;
        word_t       srcb;
        word_t       target;
        logic        branch_taken;
        logic        overflow_exc;
        logic [63:0] hilo;
    } exec_t;

endpackage

// File: execute/alu.sv
module alu (
    input  exec_pkg::word_t   a_i,
    input  exec_pkg::word_t   b_i,
    input  exec_pkg::alu_op_e alufunc_i,
    output exec_pkg::word_t   result_o,
    output logic              overflow_o
);

    exec_pkg::word_t sum;
    exec_pkg::word_t diff;
    logic [4:0]      shamt;

    assign sum   = a_i + b_i;
    assign diff  = a_i - b_i;
    // shift amount always from operand a
    assign shamt = a_i[4:0];

    always_comb begin
        unique case (alufunc_i)
            exec_pkg::ADD,
            exec_pkg::ADDU: result_o = sum;
            exec_pkg::SUB,
            exec_pkg::SUBU: result_o = diff;
            exec_pkg::AND:  result_o = a_i & b_i;
            exec_pkg::OR:   result_o = a_i | b_i;
            exec_pkg::XOR:  result_o = a_i ^ b_i;
            exec_pkg::NOR:  result_o = ~(a_i | b_i);
            exec_pkg::SLT:  result_o = {31'b0, $signed(a_i) < $signed(b_i)};
            exec_pkg::SLTU: result_o = {31'b0, a_i < b_i};
            exec_pkg::SLL:  result_o = b_i << shamt;
            exec_pkg::SRL:  result_o = b_i >> shamt;
            exec_pkg::SRA:  result_o = $signed(b_i) >>> shamt;
            exec_pkg::LUI:  result_o = {b_i[15:0], 16'b0};
            default:        result_o = '0;
        endcase
    end

    // signed overflow, trapping ops only
    always_comb begin
        unique case (alufunc_i)
            exec_pkg::ADD: begin
                // same signs in, different sign out
                overflow_o = (a_i[31] == b_i[31]) && (sum[31] != a_i[31]);
            end
            exec_pkg::SUB: begin
                overflow_o = (a_i[31] != b_i[31]) && (diff[31] != a_i[31]);
            end
            default: begin
                overflow_o = 1'b0;
            end
        endcase
    end

endmodule

// File: execute/branch_unit.sv
module branch_unit (
    input  exec_pkg::word_t   pc_i,
    input  exec_pkg::word_t   raw_instr_i,
    input  exec_pkg::word_t   rd1_i,
    input  exec_pkg::word_t   rd2_i,
    input  logic              branch_i,
    input  logic              jump_i,
    input  logic              jr_i,
    input  exec_pkg::branch_e branch_type_i,
    output exec_pkg::word_t   target_o,
    output logic              taken_o
);

    exec_pkg::word_t pc_plus4;
    exec_pkg::word_t br_offset;
    logic            cond;

    assign pc_plus4  = pc_i + 32'd4;
    assign br_offset = {{14{raw_instr_i[15]}}, raw_instr_i[15:0], 2'b00};

    always_comb begin
        unique case (branch_type_i)
            exec_pkg::BEQ:  cond = (rd1_i == rd2_i);
            exec_pkg::BNE:  cond = (rd1_i != rd2_i);
            exec_pkg::BLEZ: cond = rd1_i[31] || (rd1_i == '0);
            exec_pkg::BGTZ: cond = !rd1_i[31] && (rd1_i != '0);
            exec_pkg::BLTZ: cond = rd1_i[31];
            exec_pkg::BGEZ: cond = !rd1_i[31];
            default:        cond = 1'b0;
        endcase
    end

    // branch wins over jr, jr over j
    always_comb begin
        if (branch_i) begin
            target_o = pc_plus4 + br_offset;
        end else if (jr_i) begin
            target_o = rd1_i;
        end else if (jump_i) begin
            target_o = {pc_plus4[31:28], raw_instr_i[25:0], 2'b00};
        end else begin
            target_o = '0;
        end
    end

    assign taken_o = jump_i || jr_i || (branch_i && cond);

endmodule

// File: execute/div_unit.sv
module div_unit (
    input  logic            clk,
    input  logic            rst_n_i,
    input  logic            valid_i,
    input  exec_pkg::word_t a_i,
    input  exec_pkg::word_t b_i,
    output logic            done_o,
    output logic [63:0]     res_o
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_RUN,
        S_DONE
    } state_e;

    state_e          state_q;
    logic [4:0]      cnt_q;
    exec_pkg::word_t quo_q;
    exec_pkg::word_t rem_q;
    exec_pkg::word_t dvs_q;
    logic [32:0]     rem_sh;
    logic [33:0]     trial;
    exec_pkg::word_t rem_next;
    exec_pkg::word_t quo_next;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state_q <= S_IDLE;
            cnt_q   <= '0;
        end else begin
            unique case (state_q)
                S_IDLE: begin
                    if (valid_i) begin
                        state_q <= S_RUN;
                        cnt_q   <= '0;
                    end
                end
                S_RUN: begin
                    // 32 iterations, one quotient bit each
                    if (cnt_q == 5'd31) begin
                        state_q <= S_DONE;
                    end else begin
                        cnt_q <= cnt_q + 1'b1;
                    end
                end
                default: state_q <= S_IDLE;
            endcase
        end
    end

    // shift in next dividend bit, try subtract
    always_comb begin
        rem_sh = {rem_q, quo_q[31]};
        trial  = {1'b0, rem_sh} - {2'b0, dvs_q};
        if (!trial[33]) begin
            rem_next = trial[31:0];
            quo_next = {quo_q[30:0], 1'b1};
        end else begin
            rem_next = rem_sh[31:0];
            quo_next = {quo_q[30:0], 1'b0};
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == S_IDLE && valid_i) begin
            quo_q <= a_i;
            rem_q <= '0;
            dvs_q <= b_i;
        end else if (state_q == S_RUN) begin
            quo_q <= quo_next;
            rem_q <= rem_next;
        end
    end

    assign done_o = (state_q == S_DONE);
    assign res_o  = {rem_q, quo_q};

endmodule

// File: execute/execute.sv
module execute #(
    parameter int MUL_LATENCY = 3
) (
    input  logic             clk,
    input  logic             rst_n_i,
    input  exec_pkg::issue_t issue_i [1:0],
    output exec_pkg::exec_t  exec_o [1:0],
    output logic             e_wait_o
);

    exec_pkg::word_t  src_a [1:0];
    exec_pkg::word_t  src_b [1:0];
    exec_pkg::word_t  imm_ext [1:0];
    exec_pkg::word_t  alu_res [1:0];
    logic             alu_ovf [1:0];
    exec_pkg::word_t  br_target;
    logic             br_taken;
    logic             md_sel;
    exec_pkg::md_op_e md_op;
    logic             is_mul;
    logic             is_div;
    logic             md_signed;
    logic             neg_a;
    logic             neg_b;
    exec_pkg::word_t  mag_a;
    exec_pkg::word_t  mag_b;
    logic             mul_done;
    logic             div_done;
    logic [63:0]      mul_prod;
    logic [63:0]      div_res;
    logic [63:0]      hilo;

    for (genvar i = 0; i < 2; i++) begin : g_slot
        assign imm_ext[i] = issue_i[i].ctl.zeroext ? {16'b0, issue_i[i].imm}
                                                   : {{16{issue_i[i].imm[15]}}, issue_i[i].imm};
        assign src_a[i] = issue_i[i].ctl.shamt_valid ? {27'b0, issue_i[i].raw_instr[10:6]}
                                                     : issue_i[i].rd1;
        assign src_b[i] = (issue_i[i].ctl.alusrc == exec_pkg::IMM) ? imm_ext[i] : issue_i[i].rd2;

        alu u_alu (
            .a_i        (src_a[i]),
            .b_i        (src_b[i]),
            .alufunc_i  (issue_i[i].ctl.alufunc),
            .result_o   (alu_res[i]),
            .overflow_o (alu_ovf[i])
        );
    end

    // only slot 1 carries control flow
    branch_unit u_branch (
        .pc_i          (issue_i[1].pc),
        .raw_instr_i   (issue_i[1].raw_instr),
        .rd1_i         (issue_i[1].rd1),
        .rd2_i         (issue_i[1].rd2),
        .branch_i      (issue_i[1].ctl.branch),
        .jump_i        (issue_i[1].ctl.jump),
        .jr_i          (issue_i[1].ctl.jr),
        .branch_type_i (issue_i[1].ctl.branch_type),
        .target_o      (br_target),
        .taken_o       (br_taken)
    );

    // slot 1 wins if both ask for mul/div
    assign md_sel    = (issue_i[1].ctl.md_op != exec_pkg::MD_NONE);
    assign md_op     = issue_i[md_sel].ctl.md_op;
    assign is_mul    = (md_op == exec_pkg::MULT) || (md_op == exec_pkg::MULTU);
    assign is_div    = (md_op == exec_pkg::DIV) || (md_op == exec_pkg::DIVU);
    assign md_signed = (md_op == exec_pkg::MULT) || (md_op == exec_pkg::DIV);
    assign neg_a     = md_signed && issue_i[md_sel].rd1[31];
    assign neg_b     = md_signed && issue_i[md_sel].rd2[31];
    assign mag_a     = neg_a ? -issue_i[md_sel].rd1 : issue_i[md_sel].rd1;
    assign mag_b     = neg_b ? -issue_i[md_sel].rd2 : issue_i[md_sel].rd2;

    mul_unit #(
        .MUL_LATENCY (MUL_LATENCY)
    ) u_mul (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .valid_i (is_mul),
        .a_i     (mag_a),
        .b_i     (mag_b),
        .done_o  (mul_done),
        .prod_o  (mul_prod)
    );

    div_unit u_div (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .valid_i (is_div),
        .a_i     (mag_a),
        .b_i     (mag_b),
        .done_o  (div_done),
        .res_o   (div_res)
    );

    // sign fix, remainder follows the dividend
    always_comb begin
        hilo = '0;
        if (is_mul) begin
            hilo = (neg_a ^ neg_b) ? -mul_prod : mul_prod;
        end else if (is_div) begin
            hilo[31:0]  = (neg_a ^ neg_b) ? -div_res[31:0] : div_res[31:0];
            hilo[63:32] = neg_a ? -div_res[63:32] : div_res[63:32];
        end
    end

    always_comb begin
        for (int i = 0; i < 2; i++) begin
            exec_o[i].valid        = issue_i[i].valid;
            exec_o[i].pc           = issue_i[i].pc;
            exec_o[i].rdst         = issue_i[i].rdst;
            exec_o[i].ctl          = issue_i[i].ctl;
            exec_o[i].alu_out      = alu_res[i];
            exec_o[i].srca         = issue_i[i].rd1;
            exec_o[i].srcb         = issue_i[i].rd2;
            exec_o[i].target       = '0;
            exec_o[i].branch_taken = 1'b0;
            exec_o[i].overflow_exc = alu_ovf[i];
            exec_o[i].hilo         = '0;
        end
        if (issue_i[1].ctl.is_link) begin
            exec_o[1].alu_out = issue_i[1].pc + 32'd8;
        end
        exec_o[1].target       = br_target;
        exec_o[1].branch_taken = br_taken;
        // older slot faults, younger slot is squashed
        if (alu_ovf[1]) begin
            exec_o[0].valid        = 1'b0;
            exec_o[0].overflow_exc = 1'b0;
        end
        if (md_sel) begin
            exec_o[1].hilo = hilo;
        end else begin
            exec_o[0].hilo = hilo;
        end
    end

    assign e_wait_o = (is_mul && !mul_done) || (is_div && !div_done);

endmodule

// File: execute/mul_unit.sv
// latency must be at least 2, the product register needs a cycle
module mul_unit #(
    parameter int MUL_LATENCY = 3
) (
    input  logic            clk,
    input  logic            rst_n_i,
    input  logic            valid_i,
    input  exec_pkg::word_t a_i,
    input  exec_pkg::word_t b_i,
    output logic            done_o,
    output logic [63:0]     prod_o
);

    localparam int CNT_W = $clog2(MUL_LATENCY + 1);

    typedef enum logic {
        S_IDLE,
        S_BUSY
    } state_e;

    state_e          state_q;
    logic [CNT_W-1:0] cnt_q;
    exec_pkg::word_t a_q;
    exec_pkg::word_t b_q;
    logic [63:0]     prod_q;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state_q <= S_IDLE;
            cnt_q   <= '0;
            done_o  <= 1'b0;
        end else begin
            done_o <= 1'b0;
            unique case (state_q)
                S_IDLE: begin
                    if (valid_i) begin
                        state_q <= S_BUSY;
                        cnt_q   <= CNT_W'(MUL_LATENCY - 1);
                    end
                end
                S_BUSY: begin
                    // stay busy through the done cycle, packet leaves then
                    if (done_o) begin
                        state_q <= S_IDLE;
                    end else if (cnt_q == CNT_W'(1)) begin
                        done_o <= 1'b1;
                    end else begin
                        cnt_q <= cnt_q - 1'b1;
                    end
                end
                default: state_q <= S_IDLE;
            endcase
        end
    end

    // operand regs then product reg, maps onto dsp
    always_ff @(posedge clk) begin
        if (state_q == S_IDLE && valid_i) begin
            a_q <= a_i;
            b_q <= b_i;
        end
        prod_q <= {32'b0, a_q} * {32'b0, b_q};
    end

    assign prod_o = prod_q;

endmodule

// File: run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal -f src.f --top-module execute_tb &&
./obj_dir/Vexecute_tb +verilator+error+limit+1000 | tee /dev/stderr |
    grep -qx "all tests passed" ||
{ echo "simulation did not pass"; exit 1; }

// File: src.f
common/exec_pkg.sv
execute/alu.sv
execute/branch_unit.sv
execute/mul_unit.sv
execute/div_unit.sv
execute/execute.sv
tests/execute_asserts.sv
tests/execute_tb.sv

// File: tests/execute_asserts.sv
module execute_asserts #(
    parameter int MUL_LATENCY = 3
) (
    input  logic             clk,
    input  logic             rst_n_i,
    input  exec_pkg::issue_t issue_i [1:0],
    input  exec_pkg::exec_t  exec_o [1:0],
    input  logic             e_wait_o
);

    // read by the testbench for its closing count
    int fail_cnt = 0;

    exec_pkg::word_t exp_alu [1:0];
    logic            exp_ovf [1:0];
    logic [117:0]    exp_pass [1:0];
    exec_pkg::word_t exp_target;
    exec_pkg::word_t pc4;
    logic            exp_taken;
    logic            md_present;
    logic            md_slot;
    logic [63:0]     exp_hilo;
    int              exp_len;
    int              run_len;

    function automatic exec_pkg::word_t operand_a(exec_pkg::issue_t s);
        if (s.ctl.shamt_valid) begin
            return exec_pkg::word_t'(s.raw_instr[10:6]);
        end
        return s.rd1;
    endfunction

    function automatic exec_pkg::word_t operand_b(exec_pkg::issue_t s);
        if (s.ctl.alusrc == exec_pkg::REGB) begin
            return s.rd2;
        end
        if (s.ctl.zeroext) begin
            return {16'h0000, s.imm};
        end
        return exec_pkg::word_t'($signed(s.imm));
    endfunction

    function automatic exec_pkg::word_t alu_model(exec_pkg::alu_op_e op, exec_pkg::word_t a,
                                                  exec_pkg::word_t b);
        case (op)
            exec_pkg::ADD, exec_pkg::ADDU: return a + b;
            exec_pkg::SUB, exec_pkg::SUBU: return a - b;
            exec_pkg::AND:  return a & b;
            exec_pkg::OR:   return a | b;
            exec_pkg::XOR:  return a ^ b;
            exec_pkg::NOR:  return ~a & ~b;
            exec_pkg::SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            exec_pkg::SLTU: return (a < b) ? 32'd1 : 32'd0;
            exec_pkg::SLL:  return b << a[4:0];
            exec_pkg::SRL:  return b >> a[4:0];
            exec_pkg::SRA:  return $signed(b) >>> a[4:0];
            exec_pkg::LUI:  return b << 16;
            default:        return '0;
        endcase
    endfunction

    // top two bits of the 33-bit sign-extended sum differ on overflow
    function automatic logic overflow_model(exec_pkg::alu_op_e op, exec_pkg::word_t a,
                                            exec_pkg::word_t b);
        logic [32:0] wide;
        if (op == exec_pkg::SUB) begin
            wide = {a[31], a} - {b[31], b};
        end else begin
            wide = {a[31], a} + {b[31], b};
        end
        return (op == exec_pkg::ADD || op == exec_pkg::SUB) && (wide[32] != wide[31]);
    endfunction

    function automatic logic branch_cond(exec_pkg::branch_e t, exec_pkg::word_t r1,
                                         exec_pkg::word_t r2);
        case (t)
            exec_pkg::BEQ:  return r1 == r2;
            exec_pkg::BNE:  return r1 != r2;
            exec_pkg::BLEZ: return $signed(r1) <= 0;
            exec_pkg::BGTZ: return $signed(r1) > 0;
            exec_pkg::BLTZ: return $signed(r1) < 0;
            exec_pkg::BGEZ: return $signed(r1) >= 0;
            default:        return 1'b0;
        endcase
    endfunction

    // remainder in hi and quotient in lo
    function automatic logic [63:0] md_model(exec_pkg::md_op_e op, exec_pkg::word_t a,
                                             exec_pkg::word_t b);
        exec_pkg::word_t q;
        exec_pkg::word_t r;
        case (op)
            exec_pkg::MULT:  return {{32{a[31]}}, a} * {{32{b[31]}}, b};
            exec_pkg::MULTU: return {32'h0, a} * {32'h0, b};
            exec_pkg::DIV: begin
                q = $signed(a) / $signed(b);
                r = $signed(a) % $signed(b);
                return {r, q};
            end
            exec_pkg::DIVU:  return {a % b, a / b};
            default:         return '0;
        endcase
    endfunction

    always_comb begin
        for (int i = 0; i < 2; i++) begin
            exp_alu[i] = alu_model(issue_i[i].ctl.alufunc, operand_a(issue_i[i]),
                                   operand_b(issue_i[i]));
            exp_ovf[i] = overflow_model(issue_i[i].ctl.alufunc, operand_a(issue_i[i]),
                                        operand_b(issue_i[i]));
            // pc, rdst, ctl and both source registers travel unchanged
            exp_pass[i] = {issue_i[i].pc, issue_i[i].rdst, issue_i[i].ctl,
                           issue_i[i].rd1, issue_i[i].rd2};
        end
        if (issue_i[1].ctl.is_link) begin
            exp_alu[1] = issue_i[1].pc + 32'd8;
        end
        pc4 = issue_i[1].pc + 32'd4;
        if (issue_i[1].ctl.branch) begin
            exp_target = pc4 + (exec_pkg::word_t'($signed(issue_i[1].raw_instr[15:0])) << 2);
        end else if (issue_i[1].ctl.jr) begin
            exp_target = issue_i[1].rd1;
        end else begin
            exp_target = (pc4 & 32'hf000_0000) | {4'h0, issue_i[1].raw_instr[25:0], 2'b00};
        end
        exp_taken = issue_i[1].ctl.jump || issue_i[1].ctl.jr
                    || (issue_i[1].ctl.branch && branch_cond(issue_i[1].ctl.branch_type,
                                                             issue_i[1].rd1, issue_i[1].rd2));
        // the older slot wins the shared units
        md_slot    = issue_i[1].ctl.md_op != exec_pkg::MD_NONE;
        md_present = md_slot || (issue_i[0].ctl.md_op != exec_pkg::MD_NONE);
        exp_hilo   = md_model(issue_i[md_slot].ctl.md_op, issue_i[md_slot].rd1,
                              issue_i[md_slot].rd2);
        if (issue_i[md_slot].ctl.md_op == exec_pkg::DIV
            || issue_i[md_slot].ctl.md_op == exec_pkg::DIVU) begin
            exp_len = 33;
        end else begin
            exp_len = MUL_LATENCY;
        end
    end

    // sampled cycles of the current stall
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            run_len <= 0;
        end else if (e_wait_o) begin
            run_len <= run_len + 1;
        end else begin
            run_len <= 0;
        end
    end

    a_alu0: assert property (@(posedge clk) disable iff (!rst_n_i)
        exec_o[0].alu_out == exp_alu[0])
        else begin
            fail_cnt++;
            $error("CHECK FAILED alu_out slot 0 expected %h actual %h",
                   $sampled(exp_alu[0]), $sampled(exec_o[0].alu_out));
        end

    a_alu1: assert property (@(posedge clk) disable iff (!rst_n_i)
        exec_o[1].alu_out == exp_alu[1])
        else begin
            fail_cnt++;
            $error("CHECK FAILED alu_out slot 1 expected %h actual %h",
                   $sampled(exp_alu[1]), $sampled(exec_o[1].alu_out));
        end

    a_pass0: assert property (@(posedge clk) disable iff (!rst_n_i)
        {exec_o[0].pc, exec_o[0].rdst, exec_o[0].ctl, exec_o[0].srca, exec_o[0].srcb}
        == exp_pass[0])
        else begin
            fail_cnt++;
            $error("CHECK FAILED pass fields slot 0 expected %h actual %h",
                   $sampled(exp_pass[0]),
                   $sampled({exec_o[0].pc, exec_o[0].rdst, exec_o[0].ctl,
                             exec_o[0].srca, exec_o[0].srcb}));
        end

    a_pass1: assert property (@(posedge clk) disable iff (!rst_n_i)
        {exec_o[1].pc, exec_o[1].rdst, exec_o[1].ctl, exec_o[1].srca, exec_o[1].srcb}
        == exp_pass[1])
        else begin
            fail_cnt++;
            $error("CHECK FAILED pass fields slot 1 expected %h actual %h",
                   $sampled(exp_pass[1]),
                   $sampled({exec_o[1].pc, exec_o[1].rdst, exec_o[1].ctl,
                             exec_o[1].srca, exec_o[1].srcb}));
        end

    a_ovf1: assert property (@(posedge clk) disable iff (!rst_n_i)
        exec_o[1].overflow_exc == exp_ovf[1])
        else begin
            fail_cnt++;
            $error("CHECK FAILED overflow_exc slot 1 expected %b actual %b",
                   $sampled(exp_ovf[1]), $sampled(exec_o[1].overflow_exc));
        end

    // a slot 1 fault squashes slot 0 and hides its own fault
    a_ovf0: assert property (@(posedge clk) disable iff (!rst_n_i)
        exec_o[0].overflow_exc == (exp_ovf[0] && !exp_ovf[1]))
        else begin
            fail_cnt++;
            $error("CHECK FAILED overflow_exc slot 0 expected %b actual %b",
                   $sampled(exp_ovf[0] && !exp_ovf[1]), $sampled(exec_o[0].overflow_exc));
        end

    a_valid0: assert property (@(posedge clk) disable iff (!rst_n_i)
        exec_o[0].valid == (issue_i[0].valid && !exp_ovf[1]))
        else begin
            fail_cnt++;
            $error("CHECK FAILED valid slot 0 expected %b actual %b",
                   $sampled(issue_i[0].valid && !exp_ovf[1]), $sampled(exec_o[0].valid));
        end

    a_valid1: assert property (@(posedge clk) disable iff (!rst_n_i)
        exec_o[1].valid == issue_i[1].valid)
        else begin
            fail_cnt++;
            $error("CHECK FAILED valid slot 1 expected %b actual %b",
                   $sampled(issue_i[1].valid), $sampled(exec_o[1].valid));
        end

    a_taken: assert property (@(posedge clk) disable iff (!rst_n_i)
        exec_o[1].branch_taken == exp_taken)
        else begin
            fail_cnt++;
            $error("CHECK FAILED branch_taken expected %b actual %b",
                   $sampled(exp_taken), $sampled(exec_o[1].branch_taken));
        end

    a_target: assert property (@(posedge clk) disable iff (!rst_n_i)
        (issue_i[1].ctl.branch || issue_i[1].ctl.jump || issue_i[1].ctl.jr)
        |-> exec_o[1].target == exp_target)
        else begin
            fail_cnt++;
            $error("CHECK FAILED target expected %h actual %h",
                   $sampled(exp_target), $sampled(exec_o[1].target));
        end

    // hilo is only valid in the done cycle
    a_hilo: assert property (@(posedge clk) disable iff (!rst_n_i)
        (md_present && !e_wait_o) |-> exec_o[md_slot].hilo == exp_hilo)
        else begin
            fail_cnt++;
            $error("CHECK FAILED hilo expected %h actual %h",
                   $sampled(exp_hilo), $sampled(exec_o[md_slot].hilo));
        end

    a_wait_len: assert property (@(posedge clk) disable iff (!rst_n_i)
        (!e_wait_o && run_len != 0) |-> run_len == exp_len)
        else begin
            fail_cnt++;
            $error("CHECK FAILED e_wait_o cycles expected %0d actual %0d",
                   $sampled(exp_len), $sampled(run_len));
        end

    // also active while reset is held
    a_wait_idle: assert property (@(posedge clk) !md_present |-> !e_wait_o)
        else begin
            fail_cnt++;
            $error("CHECK FAILED e_wait_o without mul/div expected 0 actual %b",
                   $sampled(e_wait_o));
        end

endmodule

bind execute execute_asserts #(
    .MUL_LATENCY (MUL_LATENCY)
) u_asserts (
    .clk      (clk),
    .rst_n_i  (rst_n_i),
    .issue_i  (issue_i),
    .exec_o   (exec_o),
    .e_wait_o (e_wait_o)
);

// File: tests/execute_tb.sv
module execute_tb;

    localparam int MUL_LATENCY = 3;
    localparam int WAIT_LIMIT  = 64;

    logic             clk;
    logic             rst_n_i;
    exec_pkg::issue_t issue_q [1:0];
    exec_pkg::exec_t  exec_w [1:0];
    logic             e_wait_w;

    logic [31:0] lfsr_q;
    int          tests_run;
    int          tests_failed;
    int          timeouts;
    int          fails_before;

    execute #(
        .MUL_LATENCY (MUL_LATENCY)
    ) uut (
        .clk      (clk),
        .rst_n_i  (rst_n_i),
        .issue_i  (issue_q),
        .exec_o   (exec_w),
        .e_wait_o (e_wait_w)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // galois form, taps 32 30 26 25
    function automatic logic [31:0] lfsr_next(logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'ha300_0000) : (s >> 1);
    endfunction

    function automatic logic take_bit();
        logic b;
        b      = lfsr_q[0];
        lfsr_q = lfsr_next(lfsr_q);
        return b;
    endfunction

    function automatic logic [31:0] take_bits(int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            v = {v[30:0], take_bit()};
        end
        return v;
    endfunction

    function automatic exec_pkg::issue_t random_alu_slot();
        exec_pkg::issue_t s;
        s                 = '0;
        s.valid           = take_bit();
        s.pc              = take_bits(32) & 32'hffff_fffc;
        s.raw_instr       = take_bits(32);
        s.rd1             = take_bits(32);
        s.rd2             = take_bits(32);
        s.imm             = 16'(take_bits(16));
        s.rdst            = 5'(take_bits(5));
        s.ctl.alufunc     = exec_pkg::alu_op_e'(4'(take_bits(4) % 14));
        s.ctl.alusrc      = exec_pkg::alusrc_e'(take_bit());
        s.ctl.zeroext     = take_bit();
        s.ctl.shamt_valid = take_bit();
        s.ctl.md_op       = exec_pkg::MD_NONE;
        return s;
    endfunction

    function automatic exec_pkg::issue_t fixed_alu_slot(exec_pkg::alu_op_e op,
                                                         exec_pkg::word_t x, exec_pkg::word_t y);
        exec_pkg::issue_t s;
        s             = '0;
        s.valid       = 1'b1;
        s.rd1         = x;
        s.rd2         = y;
        s.ctl.alufunc = op;
        s.ctl.alusrc  = exec_pkg::REGB;
        return s;
    endfunction

    function automatic exec_pkg::issue_t random_md_slot(exec_pkg::md_op_e op);
        exec_pkg::issue_t s;
        s           = random_alu_slot();
        s.ctl.md_op = op;
        if (take_bit()) begin
            // short second operand, long quotients
            s.rd2 = {{24{s.rd2[31]}}, s.rd2[7:0]};
        end
        if (s.rd2 == '0 || (s.rd1 == 32'h8000_0000 && s.rd2 == '1)) begin
            s.rd2 = 32'd3;
        end
        return s;
    endfunction

    // drive one packet and hold it while e_wait_o is high
    task automatic send(input exec_pkg::issue_t older, input exec_pkg::issue_t younger,
                        input string name);
        int cycles;
        issue_q[1] <= older;
        issue_q[0] <= younger;
        @(posedge clk);
        cycles = 0;
        while (e_wait_w && cycles < WAIT_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        if (e_wait_w) begin
            $display("test %s: e_wait_o still high after %0d cycles", name, WAIT_LIMIT);
            timeouts++;
        end
    endtask

    // idle packet first so the last checks are counted
    task automatic finish_test(input string name);
        int errs;
        issue_q[1] <= '0;
        issue_q[0] <= '0;
        @(posedge clk);
        errs = uut.u_asserts.fail_cnt - fails_before;
        tests_run++;
        if (errs != 0 || timeouts != 0) begin
            tests_failed++;
            $display("test %s: FAIL, %0d check failures, %0d timeouts", name, errs, timeouts);
        end else begin
            $display("test %s: ok", name);
        end
        timeouts     = 0;
        fails_before = uut.u_asserts.fail_cnt;
    endtask

    initial begin
        exec_pkg::issue_t a;
        exec_pkg::issue_t b;
        exec_pkg::md_op_e op;
        logic [1:0]       kind;
        lfsr_q       = 32'hd55f_35b0;
        tests_run    = 0;
        tests_failed = 0;
        timeouts     = 0;
        fails_before = 0;
        rst_n_i    <= 1'b0;
        issue_q[0] <= '0;
        issue_q[1] <= '0;
        repeat (16) @(posedge clk);
        rst_n_i <= 1'b1;

        for (int n = 0; n < 4; n++) begin
            a = random_alu_slot();
            b = random_alu_slot();
            send(a, b, "reset_idle");
        end
        finish_test("reset_idle");

        for (int n = 0; n < 300; n++) begin
            a = random_alu_slot();
            b = random_alu_slot();
            send(a, b, "alu_random");
        end
        finish_test("alu_random");

        send(fixed_alu_slot(exec_pkg::ADD, 32'h7fff_ffff, 32'd1),
             fixed_alu_slot(exec_pkg::ADD, 32'h8000_0000, 32'hffff_ffff), "exc_priority");
        send(fixed_alu_slot(exec_pkg::ADD, 32'd1, 32'd1),
             fixed_alu_slot(exec_pkg::SUB, 32'h8000_0000, 32'd1), "exc_priority");
        send(fixed_alu_slot(exec_pkg::SUB, 32'h7fff_ffff, 32'hffff_ffff),
             fixed_alu_slot(exec_pkg::ADDU, 32'd1, 32'd2), "exc_priority");
        send(fixed_alu_slot(exec_pkg::ADDU, 32'h7fff_ffff, 32'd1),
             fixed_alu_slot(exec_pkg::SUBU, 32'h8000_0000, 32'd1), "exc_priority");
        finish_test("exc_priority");

        for (int n = 0; n < 200; n++) begin
            a       = random_alu_slot();
            a.valid = 1'b1;
            kind    = 2'(take_bits(2));
            a.ctl.branch      = (kind < 2'd2);
            a.ctl.jump        = (kind == 2'd2);
            a.ctl.jr          = (kind == 2'd3);
            a.ctl.branch_type = exec_pkg::branch_e'(3'(take_bits(3) % 6));
            a.ctl.is_link     = take_bit();
            if (take_bit()) begin
                a.rd2 = a.rd1;
            end
            if (take_bits(2) == 32'd0) begin
                a.rd1 = '0;
            end
            b = random_alu_slot();
            send(a, b, "branch_random");
        end
        finish_test("branch_random");

        for (int n = 0; n < 40; n++) begin
            op = take_bit() ? exec_pkg::MULT : exec_pkg::MULTU;
            if (take_bit()) begin
                a = random_md_slot(op);
                b = random_alu_slot();
            end else begin
                a = random_alu_slot();
                b = random_md_slot(op);
            end
            send(a, b, "mul");
        end
        // both slots ask, slot 1 takes the unit
        a = random_md_slot(exec_pkg::MULT);
        b = random_md_slot(exec_pkg::MULTU);
        send(a, b, "mul");
        finish_test("mul");

        for (int n = 0; n < 30; n++) begin
            op = take_bit() ? exec_pkg::DIV : exec_pkg::DIVU;
            if (take_bit()) begin
                a = random_md_slot(op);
                b = random_alu_slot();
            end else begin
                a = random_alu_slot();
                b = random_md_slot(op);
            end
            send(a, b, "div");
        end
        finish_test("div");

        $display("%0d tests run, %0d failed, %0d check failures", tests_run, tests_failed,
                 uut.u_asserts.fail_cnt);
        if (tests_failed == 0 && uut.u_asserts.fail_cnt == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule
